// ==== common/tracker_cfg_pkg.sv ====
`default_nettype none

package tracker_cfg_pkg;

	////////////////////////////////////////
	// Bus and datapath widths
	////////////////////////////////////////

	// Byte-wide bus, word-sized address
	localparam int ADDR_W = 32;
	// Pixel coordinates, both axes
	localparam int COORD_W = 10;
	// Accumulators and latched totals
	localparam int SUM_W = 32;

	////////////////////////////////////////
	// Buffer layout
	////////////////////////////////////////

	// Source frame buffer, video-in side
	localparam logic [ADDR_W-1:0] VIDEO_IN_BASE = 32'h0800_0000;
	// Destination frame buffer, VGA side
	localparam logic [ADDR_W-1:0] VGA_BASE = '0;

	// Row pitches as powers of two
	localparam int IN_ROW_SHIFT = 9;
	localparam int VGA_ROW_SHIFT = 10;

	// Quadrant offsets in the VGA buffer
	localparam int GREEN_Y_OFS = 240;
	localparam int BOX_X_OFS = 320;

	// Overlay colors, RGB332
	localparam logic [7:0] MARK_GREEN = 8'hff;
	localparam logic [7:0] MARK_BOX = 8'h1c;

endpackage

`default_nettype wire

// ==== common/pixel_pkg.sv ====
`default_nettype none

package pixel_pkg;

	////////////////////////////////////////
	// RGB332 pixel layout
	////////////////////////////////////////

	localparam int PIX_W = 8;

	// Field widths, MSB to LSB order
	localparam int RED_W = 3;
	localparam int GREEN_W = 3;
	localparam int BLUE_W = 2;

	// One pixel byte
	// Raw view goes straight to VGA, field view feeds the bounds compare
	typedef union packed {
		logic [PIX_W-1:0] raw;
		struct packed {
			logic [RED_W-1:0] red;
			logic [GREEN_W-1:0] green;
			logic [BLUE_W-1:0] blue;
		} rgb;
	} pixel_t;

endpackage

`default_nettype wire

// ==== tracker/video_bus_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_bus_master
	import tracker_cfg_pkg::*;
	import pixel_pkg::*;
#(
	parameter int FRAME_W = 320,
	parameter int FRAME_H = 240,
	parameter int PACE_BITS = 2
) (
	input wire logic CLOCK2_50,
	input wire logic rst_n,
	input wire logic scan_en,
	output logic [ADDR_W-1:0] bus_addr,
	output logic bus_read,
	output logic bus_write,
	output logic [PIX_W-1:0] bus_write_data,
	input wire logic bus_ack,
	input wire logic [PIX_W-1:0] bus_read_data,
	output logic pix_valid,
	output pixel_t pix,
	output logic [COORD_W-1:0] pix_x,
	output logic [COORD_W-1:0] pix_y,
	input wire logic wr_req,
	input wire logic [ADDR_W-1:0] wr_addr,
	input wire logic [PIX_W-1:0] wr_data
);

	// Bus phases
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_READ = 2'd1;
	localparam logic [1:0] ST_WAIT_WR = 2'd2;
	localparam logic [1:0] ST_WRITE = 2'd3;

	logic [1:0] state;
	// Pacing timer, only its zero phase matters
	logic [PACE_BITS-1:0] timer;
	// Next pixel to fetch
	logic [COORD_W-1:0] scan_x;
	logic [COORD_W-1:0] scan_y;
	logic [ADDR_W-1:0] rd_addr;
	logic rd_start;
	logic x_last;
	logic y_last;

	////////////////////////////////////////
	// Scan address and start condition
	////////////////////////////////////////

	// Source buffer, row pitch 2**IN_ROW_SHIFT
	assign rd_addr = VIDEO_IN_BASE + ADDR_W'(scan_x) + (ADDR_W'(scan_y) << IN_ROW_SHIFT);
	// Idle, enabled and on a pacing slot
	assign rd_start = (state == ST_IDLE) && scan_en && (timer == '0);

	assign x_last = (scan_x == COORD_W'(FRAME_W - 1));
	assign y_last = (scan_y == COORD_W'(FRAME_H - 1));

	////////////////////////////////////////
	// Control state
	////////////////////////////////////////

	always_ff @(posedge CLOCK2_50) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			timer <= '0;
			scan_x <= '0;
			scan_y <= '0;
			bus_read <= 1'b0;
			bus_write <= 1'b0;
			pix_valid <= 1'b0;
		end else begin
			timer <= timer + 1'b1;
			// Strobe lasts one cycle
			pix_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (rd_start) begin
						bus_read <= 1'b1;
						state <= ST_READ;
					end
				end
				ST_READ: begin
					// Hold the request until the ack
					if (bus_ack) begin
						bus_read <= 1'b0;
						pix_valid <= 1'b1;
						state <= ST_WAIT_WR;
						// Raster advance, wrap at frame edge
						if (x_last) begin
							scan_x <= '0;
							scan_y <= y_last ? '0 : scan_y + 1'b1;
						end else begin
							scan_x <= scan_x + 1'b1;
						end
					end
				end
				ST_WAIT_WR: begin
					// Overlay stage answers with one write
					if (wr_req) begin
						bus_write <= 1'b1;
						state <= ST_WRITE;
					end
				end
				default: begin
					if (bus_ack) begin
						bus_write <= 1'b0;
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Address, data and captured pixel
	////////////////////////////////////////

	always_ff @(posedge CLOCK2_50) begin
		if (rd_start) begin
			bus_addr <= rd_addr;
		end
		if (state == ST_WAIT_WR && wr_req) begin
			bus_addr <= wr_addr;
			bus_write_data <= wr_data;
		end
		// Byte and its position go down the pipe together
		if (state == ST_READ && bus_ack) begin
			pix.raw <= bus_read_data;
			pix_x <= scan_x;
			pix_y <= scan_y;
		end
	end

endmodule

`default_nettype wire

// ==== tracker/pixel_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_classify
	import tracker_cfg_pkg::*;
	import pixel_pkg::*;
#(
	parameter int FRAME_W = 320,
	parameter int FRAME_H = 240
) (
	input wire logic CLOCK2_50,
	input wire logic rst_n,
	input wire logic pix_valid,
	input wire pixel_t pix,
	input wire logic [COORD_W-1:0] pix_x,
	input wire logic [COORD_W-1:0] pix_y,
	input wire logic [RED_W-1:0] red_min,
	input wire logic [RED_W-1:0] red_max,
	input wire logic [GREEN_W-1:0] green_min,
	input wire logic [GREEN_W-1:0] green_max,
	input wire logic [BLUE_W-1:0] blue_min,
	input wire logic [BLUE_W-1:0] blue_max,
	input wire logic [COORD_W-1:0] box_cx,
	input wire logic [COORD_W-1:0] box_cy,
	input wire logic [COORD_W-1:0] box_r,
	output logic cls_valid,
	output pixel_t cls_pix,
	output logic [COORD_W-1:0] cls_x,
	output logic [COORD_W-1:0] cls_y,
	output logic is_green,
	output logic is_box,
	output logic frame_last
);

	logic match;
	logic [COORD_W-1:0] box_l;
	logic [COORD_W-1:0] box_r_edge;
	logic [COORD_W-1:0] box_t;
	logic [COORD_W-1:0] box_b;
	logic in_x_span;
	logic in_y_span;
	logic on_box;
	logic last_pix;

	////////////////////////////////////////
	// Color bounds
	////////////////////////////////////////

	// Red and green inclusive
	// Blue exclusive on both ends, as on the board
	assign match = (pix.rgb.red >= red_min) && (pix.rgb.red <= red_max) &&
		(pix.rgb.green >= green_min) && (pix.rgb.green <= green_max) &&
		(pix.rgb.blue > blue_min) && (pix.rgb.blue < blue_max);

	////////////////////////////////////////
	// Box outline
	////////////////////////////////////////

	// Square edges, wrap in COORD_W like the coordinates
	assign box_l = box_cx - box_r;
	assign box_r_edge = box_cx + box_r;
	assign box_t = box_cy - box_r;
	assign box_b = box_cy + box_r;

	assign in_x_span = (pix_x >= box_l) && (pix_x <= box_r_edge);
	assign in_y_span = (pix_y >= box_t) && (pix_y <= box_b);

	// Vertical edges need the row span, horizontal edges the column span
	assign on_box = ((pix_x == box_l || pix_x == box_r_edge) && in_y_span) ||
		((pix_y == box_t || pix_y == box_b) && in_x_span);

	// Bottom-right pixel closes the frame
	assign last_pix = (pix_x == COORD_W'(FRAME_W - 1)) && (pix_y == COORD_W'(FRAME_H - 1));

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	always_ff @(posedge CLOCK2_50) begin
		if (!rst_n) begin
			cls_valid <= 1'b0;
		end else begin
			cls_valid <= pix_valid;
		end
	end

	// Flags ride with the pixel
	always_ff @(posedge CLOCK2_50) begin
		if (pix_valid) begin
			cls_pix <= pix;
			cls_x <= pix_x;
			cls_y <= pix_y;
			is_green <= match;
			is_box <= on_box;
			frame_last <= last_pix;
		end
	end

endmodule

`default_nettype wire

// ==== tracker/frame_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_stats
	import tracker_cfg_pkg::*;
(
	input wire logic CLOCK2_50,
	input wire logic rst_n,
	input wire logic cls_valid,
	input wire logic is_green,
	input wire logic [COORD_W-1:0] cls_x,
	input wire logic [COORD_W-1:0] cls_y,
	input wire logic frame_last,
	output logic [SUM_W-1:0] green_total,
	output logic [SUM_W-1:0] x_sum_total,
	output logic [SUM_W-1:0] y_sum_total,
	output logic frame_done
);

	// Running sums for the frame in progress
	logic [SUM_W-1:0] green_cnt;
	logic [SUM_W-1:0] x_acc;
	logic [SUM_W-1:0] y_acc;

	// Sums with the current pixel folded in
	logic [SUM_W-1:0] green_nxt;
	logic [SUM_W-1:0] x_nxt;
	logic [SUM_W-1:0] y_nxt;

	always_comb begin
		green_nxt = green_cnt;
		x_nxt = x_acc;
		y_nxt = y_acc;
		// Only matching pixels count
		if (is_green) begin
			green_nxt = green_cnt + 1'b1;
			x_nxt = x_acc + SUM_W'(cls_x);
			y_nxt = y_acc + SUM_W'(cls_y);
		end
	end

	////////////////////////////////////////
	// Accumulate and latch
	////////////////////////////////////////

	always_ff @(posedge CLOCK2_50) begin
		if (!rst_n) begin
			green_cnt <= '0;
			x_acc <= '0;
			y_acc <= '0;
			green_total <= '0;
			x_sum_total <= '0;
			y_sum_total <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (cls_valid) begin
				if (frame_last) begin
					// Last pixel included, then start over
					green_total <= green_nxt;
					x_sum_total <= x_nxt;
					y_sum_total <= y_nxt;
					green_cnt <= '0;
					x_acc <= '0;
					y_acc <= '0;
					frame_done <= 1'b1;
				end else begin
					green_cnt <= green_nxt;
					x_acc <= x_nxt;
					y_acc <= y_nxt;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tracker/overlay_write.sv ====
`timescale 1ns/1ps
`default_nettype none

module overlay_write
	import tracker_cfg_pkg::*;
	import pixel_pkg::*;
(
	input wire logic CLOCK2_50,
	input wire logic rst_n,
	input wire logic cls_valid,
	input wire pixel_t cls_pix,
	input wire logic [COORD_W-1:0] cls_x,
	input wire logic [COORD_W-1:0] cls_y,
	input wire logic is_green,
	input wire logic is_box,
	output logic wr_req,
	output logic [ADDR_W-1:0] wr_addr,
	output logic [PIX_W-1:0] wr_data
);

	// Quadrant offsets for this pixel
	logic [ADDR_W-1:0] x_ofs;
	logic [ADDR_W-1:0] y_ofs;
	logic [PIX_W-1:0] byte_sel;
	// Final position in the VGA buffer
	logic [ADDR_W-1:0] dst_x;
	logic [ADDR_W-1:0] dst_y;
	logic [ADDR_W-1:0] dst_addr;

	////////////////////////////////////////
	// Quadrant and color select
	////////////////////////////////////////

	always_comb begin
		// Plain copy to the upper-left quadrant
		x_ofs = '0;
		y_ofs = '0;
		byte_sel = cls_pix.raw;
		if (is_green) begin
			// Match wins over the outline
			y_ofs = ADDR_W'(GREEN_Y_OFS);
			byte_sel = MARK_GREEN;
		end else if (is_box) begin
			// Outline drawn in the upper-right quadrant
			x_ofs = ADDR_W'(BOX_X_OFS);
			byte_sel = MARK_BOX;
		end
	end

	////////////////////////////////////////
	// Destination address
	////////////////////////////////////////

	// Offsets first, then the row shift
	assign dst_x = ADDR_W'(cls_x) + x_ofs;
	assign dst_y = ADDR_W'(cls_y) + y_ofs;
	assign dst_addr = VGA_BASE + dst_x + (dst_y << VGA_ROW_SHIFT);

	////////////////////////////////////////
	// Write request
	////////////////////////////////////////

	always_ff @(posedge CLOCK2_50) begin
		if (!rst_n) begin
			wr_req <= 1'b0;
		end else begin
			// One request per classified pixel
			wr_req <= cls_valid;
		end
	end

	always_ff @(posedge CLOCK2_50) begin
		if (cls_valid) begin
			wr_addr <= dst_addr;
			wr_data <= byte_sel;
		end
	end

endmodule

`default_nettype wire

// ==== src/color_tracker_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module color_tracker_top
	import tracker_cfg_pkg::*;
	import pixel_pkg::*;
#(
	parameter int FRAME_W = 320,
	parameter int FRAME_H = 240,
	parameter int PACE_BITS = 2
) (
	input wire logic CLOCK2_50,
	input wire logic rst_n,
	input wire logic scan_en,
	// Color bounds from the processor
	input wire logic [RED_W-1:0] red_min,
	input wire logic [RED_W-1:0] red_max,
	input wire logic [GREEN_W-1:0] green_min,
	input wire logic [GREEN_W-1:0] green_max,
	input wire logic [BLUE_W-1:0] blue_min,
	input wire logic [BLUE_W-1:0] blue_max,
	// Box geometry
	input wire logic [COORD_W-1:0] box_cx,
	input wire logic [COORD_W-1:0] box_cy,
	input wire logic [COORD_W-1:0] box_r,
	// Bus master side
	output logic [ADDR_W-1:0] bus_addr,
	output logic bus_read,
	output logic bus_write,
	output logic [PIX_W-1:0] bus_write_data,
	input wire logic bus_ack,
	input wire logic [PIX_W-1:0] bus_read_data,
	// Frame statistics
	output logic [SUM_W-1:0] green_total,
	output logic [SUM_W-1:0] x_sum_total,
	output logic [SUM_W-1:0] y_sum_total,
	output logic frame_done
);

	////////////////////////////////////////
	// Stage links
	////////////////////////////////////////

	// Fetch to classify
	logic pix_valid;
	pixel_t pix;
	logic [COORD_W-1:0] pix_x;
	logic [COORD_W-1:0] pix_y;

	// Classify to overlay and stats
	logic cls_valid;
	pixel_t cls_pix;
	logic [COORD_W-1:0] cls_x;
	logic [COORD_W-1:0] cls_y;
	logic is_green;
	logic is_box;
	logic frame_last;

	// Overlay back to the bus master
	logic wr_req;
	logic [ADDR_W-1:0] wr_addr;
	logic [PIX_W-1:0] wr_data;

	// Scan, pacing and bus phases
	video_bus_master #(
		.FRAME_W(FRAME_W),
		.FRAME_H(FRAME_H),
		.PACE_BITS(PACE_BITS)
	) u_video_bus_master (
		.CLOCK2_50(CLOCK2_50), .rst_n(rst_n), .scan_en(scan_en),
		.bus_addr(bus_addr), .bus_read(bus_read), .bus_write(bus_write),
		.bus_write_data(bus_write_data), .bus_ack(bus_ack), .bus_read_data(bus_read_data),
		.pix_valid(pix_valid), .pix(pix), .pix_x(pix_x), .pix_y(pix_y),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	// Threshold and outline tests
	pixel_classify #(
		.FRAME_W(FRAME_W),
		.FRAME_H(FRAME_H)
	) u_pixel_classify (
		.CLOCK2_50(CLOCK2_50), .rst_n(rst_n),
		.pix_valid(pix_valid), .pix(pix), .pix_x(pix_x), .pix_y(pix_y),
		.red_min(red_min), .red_max(red_max),
		.green_min(green_min), .green_max(green_max),
		.blue_min(blue_min), .blue_max(blue_max),
		.box_cx(box_cx), .box_cy(box_cy), .box_r(box_r),
		.cls_valid(cls_valid), .cls_pix(cls_pix), .cls_x(cls_x), .cls_y(cls_y),
		.is_green(is_green), .is_box(is_box), .frame_last(frame_last)
	);

	// Centroid side branch
	frame_stats u_frame_stats (
		.CLOCK2_50(CLOCK2_50), .rst_n(rst_n),
		.cls_valid(cls_valid), .is_green(is_green),
		.cls_x(cls_x), .cls_y(cls_y), .frame_last(frame_last),
		.green_total(green_total), .x_sum_total(x_sum_total),
		.y_sum_total(y_sum_total), .frame_done(frame_done)
	);

	// Destination address and byte
	overlay_write u_overlay_write (
		.CLOCK2_50(CLOCK2_50), .rst_n(rst_n),
		.cls_valid(cls_valid), .cls_pix(cls_pix), .cls_x(cls_x), .cls_y(cls_y),
		.is_green(is_green), .is_box(is_box),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data)
	);

endmodule

`default_nettype wire

// ==== tb/tracker_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module tracker_chk
	import tracker_cfg_pkg::*;
	import pixel_pkg::*;
(
	input wire logic CLOCK2_50,
	input wire logic rst_n,
	input wire logic bus_read,
	input wire logic bus_write,
	input wire logic bus_ack,
	input wire logic [ADDR_W-1:0] bus_addr,
	input wire logic [PIX_W-1:0] bus_write_data
);

	// Violations seen so far, read by the testbench top
	int viol_cnt = 0;

	////////////////////////////////////////
	// Bus protocol
	////////////////////////////////////////

	// One direction at a time
	rw_exclusive: assert property (@(posedge CLOCK2_50) disable iff (!rst_n)
		!(bus_read && bus_write))
	else begin
		viol_cnt++;
		$error("bus_read and bus_write high in the same cycle");
	end

	// Request level and address frozen until the ack
	req_hold: assert property (@(posedge CLOCK2_50) disable iff (!rst_n)
		((bus_read || bus_write) && !bus_ack) |=>
		($stable(bus_read) && $stable(bus_write) && $stable(bus_addr)))
	else begin
		viol_cnt++;
		$error("request or address changed before the ack");
	end

	// Write byte frozen during the write phase
	wdata_hold: assert property (@(posedge CLOCK2_50) disable iff (!rst_n)
		(bus_write && !bus_ack) |=> $stable(bus_write_data))
	else begin
		viol_cnt++;
		$error("write data changed before the ack");
	end

endmodule

bind color_tracker_top tracker_chk u_tracker_chk (
	.CLOCK2_50(CLOCK2_50),
	.rst_n(rst_n),
	.bus_read(bus_read),
	.bus_write(bus_write),
	.bus_ack(bus_ack),
	.bus_addr(bus_addr),
	.bus_write_data(bus_write_data)
);

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 20,
	parameter int RST_CYCLES = 4
) (
	output logic CLOCK2_50,
	output logic rst_n
);

	// Free-running clock
	initial begin
		CLOCK2_50 = 1'b0;
		forever #(PERIOD_NS / 2) CLOCK2_50 = ~CLOCK2_50;
	end

	// Reset held low, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge CLOCK2_50);
		@(negedge CLOCK2_50);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top
	import tracker_cfg_pkg::*;
	import pixel_pkg::*;
();

	// Small frame keeps a full scan short
	localparam int TB_W = 8;
	localparam int TB_H = 4;
	localparam int TB_PIXELS = TB_W * TB_H;

	logic CLOCK2_50;
	logic rst_n;
	logic scan_en;
	logic [RED_W-1:0] red_min;
	logic [RED_W-1:0] red_max;
	logic [GREEN_W-1:0] green_min;
	logic [GREEN_W-1:0] green_max;
	logic [BLUE_W-1:0] blue_min;
	logic [BLUE_W-1:0] blue_max;
	logic [COORD_W-1:0] box_cx;
	logic [COORD_W-1:0] box_cy;
	logic [COORD_W-1:0] box_r;
	logic [ADDR_W-1:0] bus_addr;
	logic bus_read;
	logic bus_write;
	logic [PIX_W-1:0] bus_write_data;
	logic bus_ack = 1'b0;
	logic [PIX_W-1:0] bus_read_data = '0;
	logic [SUM_W-1:0] green_total;
	logic [SUM_W-1:0] x_sum_total;
	logic [SUM_W-1:0] y_sum_total;
	logic frame_done;

	// Source image in raster order
	logic [7:0] img [TB_PIXELS];
	// Bus traffic in ack order
	logic [ADDR_W-1:0] rd_log [$];
	logic [ADDR_W-1:0] wr_addr_log [$];
	logic [PIX_W-1:0] wr_data_log [$];

	integer seed = 32'h88d8;
	int ack_delay = 0;
	bit pending = 1'b0;
	int done_cnt = 0;
	int value_errs = 0;
	int timeout_errs = 0;
	// Next pixel the scan should fetch
	int pos_x = 0;
	int pos_y = 0;

	tb_clock #(.PERIOD_NS(20), .RST_CYCLES(4)) u_tb_clock (
		.CLOCK2_50(CLOCK2_50),
		.rst_n(rst_n)
	);

	color_tracker_top #(.FRAME_W(TB_W), .FRAME_H(TB_H), .PACE_BITS(2)) u_color_tracker_top (
		.CLOCK2_50(CLOCK2_50), .rst_n(rst_n), .scan_en(scan_en),
		.red_min(red_min), .red_max(red_max),
		.green_min(green_min), .green_max(green_max),
		.blue_min(blue_min), .blue_max(blue_max),
		.box_cx(box_cx), .box_cy(box_cy), .box_r(box_r),
		.bus_addr(bus_addr), .bus_read(bus_read), .bus_write(bus_write),
		.bus_write_data(bus_write_data), .bus_ack(bus_ack), .bus_read_data(bus_read_data),
		.green_total(green_total), .x_sum_total(x_sum_total),
		.y_sum_total(y_sum_total), .frame_done(frame_done)
	);

	////////////////////////////////////////
	// Memory responder
	////////////////////////////////////////

	// Source byte at a video-in address, zero outside the frame
	function automatic logic [7:0] read_image(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] ofs;
		int x;
		int y;
		ofs = addr - VIDEO_IN_BASE;
		x = int'(ofs & ((32'd1 << IN_ROW_SHIFT) - 32'd1));
		y = int'(ofs >> IN_ROW_SHIFT);
		if (x < TB_W && y < TB_H) begin
			return img[y * TB_W + x];
		end
		return 8'h00;
	endfunction

	// One ack per request, random delay of 0 to 3 cycles
	always @(negedge CLOCK2_50) begin
		bus_ack <= 1'b0;
		if (rst_n !== 1'b1) begin
			pending = 1'b0;
		end else if ((bus_read || bus_write) && !bus_ack) begin
			if (!pending) begin
				pending = 1'b1;
				ack_delay = $random(seed) & 3;
			end
			if (ack_delay == 0) begin
				pending = 1'b0;
				bus_ack <= 1'b1;
				if (bus_read) begin
					rd_log.push_back(bus_addr);
					bus_read_data <= read_image(bus_addr);
				end else begin
					wr_addr_log.push_back(bus_addr);
					wr_data_log.push_back(bus_write_data);
				end
			end else begin
				ack_delay--;
			end
		end
	end

	// Frame-end pulses, sampled mid-cycle
	always @(negedge CLOCK2_50) begin
		if (rst_n === 1'b1 && frame_done === 1'b1) begin
			done_cnt++;
		end
	end

	////////////////////////////////////////
	// Reference rules
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			value_errs++;
			$display("FAILED %s: expected %h, got %h", name, exp, got);
		end
	endtask

	// RGB332, red and green inclusive, blue exclusive
	function automatic bit pixel_matches(input logic [7:0] p);
		int r;
		int g;
		int b;
		r = int'(p[7:5]);
		g = int'(p[4:2]);
		b = int'(p[1:0]);
		return (r >= int'(red_min)) && (r <= int'(red_max)) &&
			(g >= int'(green_min)) && (g <= int'(green_max)) &&
			(b > int'(blue_min)) && (b < int'(blue_max));
	endfunction

	// Outline means Chebyshev distance equals the half side
	function automatic bit on_outline(input int x, input int y);
		int dx;
		int dy;
		dx = x - int'(box_cx);
		dy = y - int'(box_cy);
		if (dx < 0) begin
			dx = -dx;
		end
		if (dy < 0) begin
			dy = -dy;
		end
		return ((dx > dy) ? dx : dy) == int'(box_r);
	endfunction

	task automatic expect_write(input int x, input int y, output logic [31:0] addr,
		output logic [7:0] data);
		logic [7:0] p;
		p = img[y * TB_W + x];
		// Match first, then outline, else plain copy
		if (pixel_matches(p)) begin
			addr = VGA_BASE + 32'(x) + (32'(y + GREEN_Y_OFS) << VGA_ROW_SHIFT);
			data = MARK_GREEN;
		end else if (on_outline(x, y)) begin
			addr = VGA_BASE + 32'(x + BOX_X_OFS) + (32'(y) << VGA_ROW_SHIFT);
			data = MARK_BOX;
		end else begin
			addr = VGA_BASE + 32'(x) + (32'(y) << VGA_ROW_SHIFT);
			data = p;
		end
	endtask

	////////////////////////////////////////
	// Scan driver
	////////////////////////////////////////

	// Let n pixels through, then check each read and write
	task automatic run_pixels(input string name, input int n);
		int base;
		int waited;
		int i;
		logic [31:0] exp_addr;
		logic [7:0] exp_data;
		base = wr_addr_log.size();
		@(negedge CLOCK2_50);
		scan_en = 1'b1;
		waited = 0;
		while (wr_addr_log.size() < base + n && waited < n * 40 + 20) begin
			@(negedge CLOCK2_50);
			waited++;
		end
		scan_en = 1'b0;
		if (wr_addr_log.size() < base + n || rd_log.size() < base + n) begin
			timeout_errs++;
			$display("%s: timed out waiting for %0d pixel writes", name, n);
		end else begin
			for (i = 0; i < n; i++) begin
				exp_addr = VIDEO_IN_BASE + 32'(pos_x) + (32'(pos_y) << IN_ROW_SHIFT);
				check_value(name, exp_addr, rd_log[base + i]);
				expect_write(pos_x, pos_y, exp_addr, exp_data);
				check_value(name, exp_addr, wr_addr_log[base + i]);
				check_value(name, 32'(exp_data), 32'(wr_data_log[base + i]));
				// Raster advance with wrap
				pos_x++;
				if (pos_x == TB_W) begin
					pos_x = 0;
					pos_y = (pos_y + 1) % TB_H;
				end
			end
		end
	endtask

	// Finish the frame in progress
	task automatic align_frame(input string name);
		if (pos_x != 0 || pos_y != 0) begin
			run_pixels(name, TB_PIXELS - (pos_y * TB_W + pos_x));
		end
	endtask

	// Box at (3,1) half side 1, a few hand-placed pixels
	task automatic load_overlay_scene();
		int i;
		@(negedge CLOCK2_50);
		red_min = 3'd2;
		red_max = 3'd5;
		green_min = 3'd3;
		green_max = 3'd6;
		blue_min = 2'd0;
		blue_max = 2'd3;
		box_cx = 10'd3;
		box_cy = 10'd1;
		box_r = 10'd1;
		for (i = 0; i < TB_PIXELS; i++) begin
			img[i] = 8'(i * 37 + 91);
		end
		img[0 * TB_W + 2] = 8'h71;
		img[0 * TB_W + 3] = 8'h70;
		img[1 * TB_W + 3] = 8'h00;
		img[2 * TB_W + 4] = 8'h00;
		img[3 * TB_W + 6] = 8'h73;
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_reset_idle();
		int i;
		for (i = 0; i < 16; i++) begin
			@(negedge CLOCK2_50);
			check_value("reset_idle", 32'd0, 32'({bus_read, bus_write, frame_done}));
		end
		check_value("reset_idle", 32'd0, green_total);
		check_value("reset_idle", 32'd0, x_sum_total);
		check_value("reset_idle", 32'd0, y_sum_total);
	endtask

	task automatic test_raster_order();
		int base;
		int i;
		for (i = 0; i < TB_PIXELS; i++) begin
			img[i] = 8'(i * 37 + 91);
		end
		base = rd_log.size();
		run_pixels("raster_order", TB_PIXELS + 2);
		if (rd_log.size() >= base + TB_PIXELS + 2) begin
			// Last pixel, then back to the origin
			check_value("raster_order", VIDEO_IN_BASE + 32'd7 + (32'd3 << IN_ROW_SHIFT),
				rd_log[base + TB_PIXELS - 1]);
			check_value("raster_order", VIDEO_IN_BASE, rd_log[base + TB_PIXELS]);
			check_value("raster_order", VIDEO_IN_BASE + 32'd1, rd_log[base + TB_PIXELS + 1]);
		end
	endtask

	task automatic test_green_priority();
		int base;
		load_overlay_scene();
		align_frame("green_priority");
		base = wr_addr_log.size();
		run_pixels("green_priority", TB_PIXELS);
		if (wr_addr_log.size() >= base + TB_PIXELS) begin
			// (2,0) matches and lies on the top edge
			check_value("green_priority", VGA_BASE + 32'd2 + (32'(GREEN_Y_OFS) << VGA_ROW_SHIFT),
				wr_addr_log[base + 2]);
			check_value("green_priority", 32'(MARK_GREEN), 32'(wr_data_log[base + 2]));
		end
	endtask

	task automatic test_box_and_copy();
		int base;
		load_overlay_scene();
		align_frame("box_and_copy");
		base = wr_addr_log.size();
		run_pixels("box_and_copy", TB_PIXELS);
		if (wr_addr_log.size() >= base + TB_PIXELS) begin
			// (4,2) corner, red out of range
			check_value("box_and_copy", VGA_BASE + 32'(4 + BOX_X_OFS) + (32'd2 << VGA_ROW_SHIFT),
				wr_addr_log[base + 2 * TB_W + 4]);
			check_value("box_and_copy", 32'(MARK_BOX), 32'(wr_data_log[base + 2 * TB_W + 4]));
			// (3,0) blue on the lower bound
			check_value("box_and_copy", VGA_BASE + 32'(3 + BOX_X_OFS), wr_addr_log[base + 3]);
			check_value("box_and_copy", 32'(MARK_BOX), 32'(wr_data_log[base + 3]));
			// (6,3) blue on the upper bound, off the box
			check_value("box_and_copy", VGA_BASE + 32'd6 + (32'd3 << VGA_ROW_SHIFT),
				wr_addr_log[base + 3 * TB_W + 6]);
			check_value("box_and_copy", 32'h73, 32'(wr_data_log[base + 3 * TB_W + 6]));
			// Box center is inside, not outline
			check_value("box_and_copy", VGA_BASE + 32'd3 + (32'd1 << VGA_ROW_SHIFT),
				wr_addr_log[base + TB_W + 3]);
			check_value("box_and_copy", 32'h00, 32'(wr_data_log[base + TB_W + 3]));
		end
	endtask

	// One whole frame, totals against sums over the image
	task automatic run_stats_frame(input string name);
		int i;
		int n_done;
		int exp_cnt;
		int exp_x;
		int exp_y;
		exp_cnt = 0;
		exp_x = 0;
		exp_y = 0;
		for (i = 0; i < TB_PIXELS; i++) begin
			if (pixel_matches(img[i])) begin
				exp_cnt++;
				exp_x += i % TB_W;
				exp_y += i / TB_W;
			end
		end
		n_done = done_cnt;
		run_pixels(name, TB_PIXELS);
		check_value(name, 32'd1, 32'(done_cnt - n_done));
		check_value(name, 32'(exp_cnt), green_total);
		check_value(name, 32'(exp_x), x_sum_total);
		check_value(name, 32'(exp_y), y_sum_total);
	endtask

	task automatic test_frame_stats();
		int i;
		align_frame("frame_stats");
		@(negedge CLOCK2_50);
		red_min = 3'd0;
		red_max = 3'd7;
		green_min = 3'd4;
		green_max = 3'd7;
		blue_min = 2'd0;
		blue_max = 2'd3;
		for (i = 0; i < TB_PIXELS; i++) begin
			img[i] = 8'($random(seed));
		end
		run_stats_frame("frame_stats_a");
		// Green field cleared, then three matches incl. the last pixel
		for (i = 0; i < TB_PIXELS; i++) begin
			img[i] = 8'(i * 37 + 91) & 8'he3;
		end
		img[1 * TB_W + 1] = 8'h15;
		img[2 * TB_W + 5] = 8'h15;
		img[3 * TB_W + 7] = 8'h15;
		run_stats_frame("frame_stats_b");
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int waited;
		int proto_errs;
		scan_en = 1'b0;
		red_min = 3'd2;
		red_max = 3'd5;
		green_min = 3'd3;
		green_max = 3'd6;
		blue_min = 2'd0;
		blue_max = 2'd3;
		box_cx = 10'd3;
		box_cy = 10'd1;
		box_r = 10'd1;
		waited = 0;
		while (rst_n !== 1'b1 && waited < 20) begin
			@(negedge CLOCK2_50);
			waited++;
		end
		if (rst_n !== 1'b1) begin
			timeout_errs++;
			$display("reset was never released");
		end
		test_reset_idle();
		test_raster_order();
		test_green_priority();
		test_box_and_copy();
		test_frame_stats();
		repeat (4) @(negedge CLOCK2_50);
		proto_errs = u_color_tracker_top.u_tracker_chk.viol_cnt;
		$display("Error counts: %0d value, %0d timeout, %0d protocol",
			value_errs, timeout_errs, proto_errs);
		if (value_errs + timeout_errs + proto_errs == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
common/tracker_cfg_pkg.sv
common/pixel_pkg.sv
tracker/video_bus_master.sv
tracker/pixel_classify.sv
tracker/frame_stats.sv
tracker/overlay_write.sv
src/color_tracker_top.sv
tb/tracker_chk.sv
tb/tb_clock.sv
tb/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the color tracker testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG" \
	&& verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f \
	&& ./obj_dir/Vtb_top +verilator+error+limit+1000 2>&1 | tee "$LOG" \
	|| { echo "Build or simulation run failed"; exit 1; }

# Verdict comes from the log
grep -q "Finished with errors" "$LOG" \
	&& { echo "Simulation FAILED"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }
